// ==== bch_pkg.sv ====
// code constants for the BCH(15,7) double error correcting encoder
// FSM state encodings for the input and output handshakes
// codeword type with raw and field views

package bch_pkg;

	// ========================================
	// code geometry
	// ========================================
	localparam int bch_n = 15;
	localparam int bch_k = 7;
	localparam int bch_ecc = 8;

	// generator x^8+x^7+x^6+x^4+1, the x^8 term is implied
	localparam logic [bch_ecc-1:0] bch_gen_poly = 8'hD1;

	// counts the message chunks, one bit each
	localparam int bch_cnt_w = $clog2(bch_k);

	// ========================================
	// handshake FSM states
	// ========================================
	localparam logic [1:0] slc_idle = 2'd0;
	localparam logic [1:0] slc_ack = 2'd1;
	localparam logic [1:0] slc_release = 2'd2;

	localparam logic [1:0] asm_free = 2'd0;
	localparam logic [1:0] asm_take = 2'd1;
	localparam logic [1:0] asm_req = 2'd2;
	localparam logic [1:0] asm_release = 2'd3;

	// the message sits above the parity, as a systematic codeword
	typedef union packed {
		logic [bch_n-1:0] raw;
		struct packed {
			logic [bch_k-1:0] msg;
			logic [bch_ecc-1:0] ecc;
		} f;
	} bch_codeword_t;

endpackage

// ==== bch_msg_slicer.sv ====
// input four-phase handshake with message capture
// serial chunk stream, most significant bit first

`timescale 1ns/1ps

module bch_msg_slicer (
	input logic clk,
	input logic reset,
	input logic in_req,
	input logic [bch_pkg::bch_k-1:0] in_msg,
	input logic parity_held,
	output logic in_ack,
	output logic chunk,
	output logic chunk_valid,
	output logic chunk_first,
	output logic chunk_last
);
	import bch_pkg::*;

	logic [1:0] state;
	logic [bch_k-1:0] shreg;
	logic [bch_cnt_w-1:0] cnt;
	logic able;
	logic accept;

	// a new message waits until the stream is done and the last result has left
	assign able = (state == slc_idle) && !chunk_valid && !parity_held;
	assign accept = in_req && able;
	assign in_ack = (state != slc_idle);

	assign chunk = shreg[bch_k-1];
	assign chunk_first = chunk_valid && (cnt == '0);
	assign chunk_last = chunk_valid && (cnt == bch_cnt_w'(bch_k - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= slc_idle;
			chunk_valid <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				slc_idle: begin
					if (accept)
						state <= slc_ack;
				end
				// the source may already have released in_req here
				slc_ack: state <= in_req ? slc_release : slc_idle;
				slc_release: begin
					if (!in_req)
						state <= slc_idle;
				end
				default: state <= slc_idle;
			endcase

			// the stream starts the cycle after in_ack rises
			if (state == slc_ack) begin
				chunk_valid <= 1'b1;
				cnt <= '0;
			end else if (chunk_valid) begin
				cnt <= cnt + 1'b1;
				if (chunk_last)
					chunk_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == slc_idle && accept)
			shreg <= in_msg;
		else if (chunk_valid)
			shreg <= {shreg[bch_k-2:0], 1'b0};
	end

endmodule

// ==== bch_parity_lfsr.sv ====
// serial Galois division by the generator polynomial
// holds the remainder as parity until the assembler takes it

`timescale 1ns/1ps

module bch_parity_lfsr (
	input logic clk,
	input logic reset,
	input logic chunk,
	input logic chunk_valid,
	input logic chunk_first,
	input logic chunk_last,
	input logic take,
	output logic [bch_pkg::bch_ecc-1:0] parity,
	output logic parity_held
);
	import bch_pkg::*;

	logic [bch_ecc-1:0] rem;
	logic [bch_ecc-1:0] base;
	logic [bch_ecc-1:0] rem_next;
	logic fb;

	// ========================================
	// division step
	// ========================================

	// every message starts from an empty remainder
	assign base = chunk_first ? '0 : rem;
	assign fb = base[bch_ecc-1] ^ chunk;
	assign rem_next = {base[bch_ecc-2:0], 1'b0} ^ ({bch_ecc{fb}} & bch_gen_poly);

	always_ff @(posedge clk) begin
		if (chunk_valid)
			rem <= rem_next;
	end

	// no chunks arrive while held, so the remainder stays frozen
	assign parity = rem;

	// ========================================
	// held flag
	// ========================================
	always_ff @(posedge clk) begin
		if (reset)
			parity_held <= 1'b0;
		else if (chunk_valid && chunk_last)
			parity_held <= 1'b1;
		else if (take)
			parity_held <= 1'b0;
	end

endmodule

// ==== bch_data_collector.sv ====
// rebuilds the message word from the chunk stream
// and holds it until the assembler takes it

`timescale 1ns/1ps

module bch_data_collector (
	input logic clk,
	input logic reset,
	input logic chunk,
	input logic chunk_valid,
	input logic chunk_last,
	input logic take,
	output logic [bch_pkg::bch_k-1:0] msg_word,
	output logic msg_held
);
	import bch_pkg::*;

	logic [bch_k-1:0] shreg;

	// first chunk is the top bit, so it ends up in the msb after seven shifts
	always_ff @(posedge clk) begin
		if (chunk_valid)
			shreg <= {shreg[bch_k-2:0], chunk};
	end

	assign msg_word = shreg;

	// rises together with parity_held in the LFSR
	always_ff @(posedge clk) begin
		if (reset)
			msg_held <= 1'b0;
		else if (chunk_valid && chunk_last)
			msg_held <= 1'b1;
		else if (take)
			msg_held <= 1'b0;
	end

endmodule

// ==== bch_code_assembler.sv ====
// joins message and parity into one codeword register
// runs the output four-phase handshake with a single slot

`timescale 1ns/1ps

module bch_code_assembler (
	input logic clk,
	input logic reset,
	input logic [bch_pkg::bch_k-1:0] msg_word,
	input logic [bch_pkg::bch_ecc-1:0] parity,
	input logic msg_held,
	input logic out_ack,
	output logic take,
	output logic out_req,
	output bch_pkg::bch_codeword_t out_code
);
	import bch_pkg::*;

	logic [1:0] state;
	bch_codeword_t code_q;

	assign take = (state == asm_take);
	assign out_req = (state == asm_req);
	assign out_code = code_q;

	// ========================================
	// output slot FSM
	// ========================================

	// msg_held alone is enough, parity_held always rises and falls with it
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= asm_free;
		end else begin
			case (state)
				asm_free: begin
					if (msg_held)
						state <= asm_take;
				end
				asm_take: state <= asm_req;
				asm_req: begin
					if (out_ack)
						state <= asm_release;
				end
				// the slot frees once the sink has let go of out_ack
				asm_release: begin
					if (!out_ack)
						state <= asm_free;
				end
				default: state <= asm_free;
			endcase
		end
	end

	// copied in the take cycle, held stable through the whole handshake
	always_ff @(posedge clk) begin
		if (state == asm_take) begin
			code_q.f.msg <= msg_word;
			code_q.f.ecc <= parity;
		end
	end

endmodule

// ==== bch_frame_encoder.sv ====
// top level of the streaming BCH(15,7) encoder
// slicer, parity LFSR, data collector and code assembler

`timescale 1ns/1ps

module bch_frame_encoder (
	input logic clk,
	input logic reset,
	input logic in_req,
	input logic [bch_pkg::bch_k-1:0] in_msg,
	input logic out_ack,
	output logic in_ack,
	output logic out_req,
	output logic [bch_pkg::bch_n-1:0] out_code
);
	import bch_pkg::*;

	// chunk stream, shared by the LFSR and the collector
	logic chunk;
	logic chunk_valid;
	logic chunk_first;
	logic chunk_last;

	// held results and the take pulse that releases them
	logic [bch_ecc-1:0] parity;
	logic parity_held;
	logic [bch_k-1:0] msg_word;
	logic msg_held;
	logic take;
	bch_codeword_t code;

	bch_msg_slicer u_slicer (
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.in_msg(in_msg),
		.parity_held(parity_held),
		.in_ack(in_ack),
		.chunk(chunk),
		.chunk_valid(chunk_valid),
		.chunk_first(chunk_first),
		.chunk_last(chunk_last)
	);

	bch_parity_lfsr u_lfsr (
		.clk(clk),
		.reset(reset),
		.chunk(chunk),
		.chunk_valid(chunk_valid),
		.chunk_first(chunk_first),
		.chunk_last(chunk_last),
		.take(take),
		.parity(parity),
		.parity_held(parity_held)
	);

	bch_data_collector u_collector (
		.clk(clk),
		.reset(reset),
		.chunk(chunk),
		.chunk_valid(chunk_valid),
		.chunk_last(chunk_last),
		.take(take),
		.msg_word(msg_word),
		.msg_held(msg_held)
	);

	bch_code_assembler u_assembler (
		.clk(clk),
		.reset(reset),
		.msg_word(msg_word),
		.parity(parity),
		.msg_held(msg_held),
		.out_ack(out_ack),
		.take(take),
		.out_req(out_req),
		.out_code(code)
	);

	assign out_code = code.raw;

endmodule

// ==== tb_bch_frame_encoder.sv ====
// testbench for the streaming BCH(15,7) encoder
// reference division, four-phase source and sink, scoreboard queue
// protocol assertions and watchdog

`timescale 1ns/1ps

module tb_bch_frame_encoder;
	import bch_pkg::*;

	localparam int reset_cycles = 16;
	localparam int n_random = 64;
	localparam int n_slow = 16;
	localparam int msg_count = 3 + n_random + n_slow;
	localparam int drain_cycles = 40;

	logic clk;
	logic reset;
	logic in_req;
	logic [bch_k-1:0] in_msg;
	logic out_ack;
	logic in_ack;
	logic out_req;
	logic [bch_n-1:0] out_code;

	logic [31:0] rng_state = 32'd1961;
	logic slow_sink = 1'b0;
	int received = 0;
	logic [bch_n-1:0] exp_q[$];
	string name_q[$];

	bch_frame_encoder dut0 (
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.in_msg(in_msg),
		.out_ack(out_ack),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_code(out_code)
	);

	always #5 clk = ~clk;

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// long division of a 15-bit word by x^8 + bch_gen_poly
	function automatic logic [bch_ecc-1:0] poly_rem(input logic [bch_n-1:0] word);
		logic [bch_n-1:0] r;
		r = word;
		for (int i = bch_n - 1; i >= bch_ecc; i--) begin
			if (r[i])
				r[i -: bch_ecc + 1] = r[i -: bch_ecc + 1] ^ {1'b1, bch_gen_poly};
		end
		return r[bch_ecc-1:0];
	endfunction

	function automatic logic [bch_n-1:0] ref_code(input logic [bch_k-1:0] msg);
		return {msg, poly_rem({msg, {bch_ecc{1'b0}}})};
	endfunction

	task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
		$display("Done: errors found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic fail_plain(input string what);
		$display("[ERROR] %s", what);
		$display("Done: errors found");
		$fatal(1, "stopping at first error");
	endtask

	// everything the testbench drives changes 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ========================================
	// source and sink
	// ========================================
	task automatic send_msg(input logic [bch_k-1:0] msg, input logic [bch_n-1:0] expected,
			input string name);
		int hold;
		exp_q.push_back(expected);
		name_q.push_back(name);
		in_msg = msg;
		in_req = 1'b1;
		do begin
			next_cycle();
		end while (!in_ack);
		// the source may keep in_req up for a few cycles after in_ack
		hold = int'(next_rand() % 4);
		repeat (hold)
			next_cycle();
		in_req = 1'b0;
		do begin
			next_cycle();
		end while (in_ack);
	endtask

	task automatic check_code(input logic [bch_n-1:0] code);
		logic [bch_n-1:0] exp;
		string name;
		if (exp_q.size() == 0) begin
			fail_plain("out_req came up with no message pending");
		end else begin
			exp = exp_q.pop_front();
			name = name_q.pop_front();
			assert (poly_rem(code) == '0)
				else fail_value({name, " remainder"}, 32'd0, 32'(poly_rem(code)));
			assert (code == exp)
				else fail_value(name, 32'(exp), 32'(code));
			received++;
		end
	endtask

	task automatic serve_output();
		int delay;
		logic [bch_n-1:0] code;
		forever begin
			do begin
				next_cycle();
			end while (!out_req);
			// long stalls keep the output slot full and push back on the input
			if (slow_sink)
				delay = 8 + int'(next_rand() % 23);
			else
				delay = int'(next_rand() % 6);
			repeat (delay)
				next_cycle();
			code = out_code;
			check_code(code);
			out_ack = 1'b1;
			do begin
				next_cycle();
			end while (out_req);
			out_ack = 1'b0;
		end
	endtask

	// ========================================
	// protocol assertions
	// ========================================
	assert property (@(posedge clk) $past(reset) |-> (!in_ack && !out_req))
		else fail_plain("in_ack or out_req high during or right after reset");

	assert property (@(posedge clk) disable iff (reset) $rose(in_ack) |-> $past(in_req))
		else fail_plain("in_ack rose while in_req was low");

	assert property (@(posedge clk) disable iff (reset) (in_ack && in_req) |=> in_ack)
		else fail_plain("in_ack dropped before in_req fell");

	assert property (@(posedge clk) disable iff (reset) (out_req && !out_ack) |=> out_req)
		else fail_plain("out_req dropped before out_ack was seen");

	assert property (@(posedge clk) disable iff (reset)
			(out_req && !out_ack) |=> $stable(out_code))
		else fail_plain("out_code changed while waiting for out_ack");

	// ========================================
	// stimulus
	// ========================================
	initial begin
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		in_req = 1'b0;
		in_msg = '0;
		out_ack = 1'b0;
		repeat (reset_cycles)
			@(posedge clk);
		#1;
		reset = 1'b0;

		fork
			serve_output();
		join_none

		// message 1 leaves x^8 mod g, which is the generator's low part itself
		send_msg(7'h00, '0, "zero_msg");
		send_msg(7'h01, {7'h01, 8'hD1}, "one_msg");
		send_msg(7'h7F, ref_code(7'h7F), "ones_msg");

		for (int i = 0; i < n_random; i++) begin
			r = next_rand();
			send_msg(r[bch_k-1:0], ref_code(r[bch_k-1:0]), "random_msg");
		end

		slow_sink = 1'b1;
		for (int i = 0; i < n_slow; i++) begin
			r = next_rand();
			send_msg(r[bch_k-1:0], ref_code(r[bch_k-1:0]), "backpressure_msg");
		end

		while (received < msg_count)
			next_cycle();

		// a repeated codeword would show up as a further request
		repeat (drain_cycles)
			next_cycle();

		if (!out_req) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_plain("out_req came up again after the last codeword");
		end
	end

	initial begin
		repeat (reset_cycles + msg_count * 40 + drain_cycles)
			@(posedge clk);
		fail_plain("watchdog expired before all codewords came out");
	end

endmodule

// ==== bch_frame_encoder.f ====
bch_pkg.sv
bch_msg_slicer.sv
bch_parity_lfsr.sv
bch_data_collector.sv
bch_code_assembler.sv
bch_frame_encoder.sv
tb_bch_frame_encoder.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_bch_frame_encoder \
		-f bch_frame_encoder.f
	./obj_dir/Vtb_bch_frame_encoder | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
